// ==== hw/mem_pkg.sv ====
package mem_pkg;

	localparam int WORD_W = 16;                     // processor data word
	localparam int ADDR_W = 16;                     // byte address

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// words moved per line fill
	localparam int BLOCK_WORDS = 8;

	// word-addressed memory, one word per two bytes
	localparam int MEM_WORDS = 2 ** (ADDR_W - 1);

endpackage

// ==== hw/cache_pkg.sv ====
package cache_pkg;

	// byte address layout: tttt tsss ssss wwwb
	localparam int OFFSET_W   = 4;                  // byte offset within a block
	localparam int WORD_SEL_W = 3;                  // word within a block
	localparam int SET_W      = 7;                  // set index
	localparam int TAG_W      = 5;                  // tag above the set index

	localparam int WORD_LSB = 1;                    // bit 0 picks the byte in a word
	localparam int SET_LSB  = OFFSET_W;
	localparam int TAG_LSB  = OFFSET_W + SET_W;

	localparam int NUM_SETS = 2 ** SET_W;           // 128 lines, direct mapped

	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [SET_W-1:0]      set_t;
	typedef logic [WORD_SEL_W-1:0] word_sel_t;

	// metadata word, valid on top of the tag
	typedef logic [TAG_W:0] meta_t;

	localparam int META_VALID = TAG_W;              // bit position of valid in meta_t

endpackage

// ==== hw/cache_fill_fsm.sv ====
module cache_fill_fsm
	import cache_pkg::*, mem_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      miss,             // request missed while idle
	input  addr_t     miss_addr,        // address of the missing request
	input  logic      mem_data_valid,   // one fill word is back from memory
	output logic      busy,
	output logic      mem_read,         // issue a word read this cycle
	output addr_t     fill_addr,        // address of the word being issued
	output word_sel_t fill_word,        // data array slot for returning word
	output logic      write_data_array,
	output logic      write_tag_array
);

	typedef enum logic [1:0] {
		IDLE,
		FILL,
		TAG
	} fill_state_t;

	localparam int CNT_W = WORD_SEL_W + 1;          // must reach BLOCK_WORDS

	fill_state_t state;
	addr_t       base_addr;                          // block aligned miss address
	logic [CNT_W-1:0] issue_cnt;                     // reads issued so far
	word_sel_t   rcv_cnt;                            // words received so far
	logic        last_word;

	assign last_word = mem_data_valid && (rcv_cnt == word_sel_t'(BLOCK_WORDS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			issue_cnt <= '0;
			rcv_cnt   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (miss) begin
						state     <= FILL;
						issue_cnt <= '0;
						rcv_cnt   <= '0;
					end
				end
				FILL: begin
					if (mem_read)
						issue_cnt <= issue_cnt + 1'b1;  // keeps issuing while words return
					if (mem_data_valid)
						rcv_cnt <= rcv_cnt + 1'b1;
					if (last_word)
						state <= TAG;                   // whole block is in the data array
				end
				TAG:     state <= IDLE;             // tag written at this edge
				default: state <= IDLE;
			endcase
		end
	end

	// block base captured once, request is held anyway
	always_ff @(posedge clk) begin
		if (state == IDLE && miss)
			base_addr <= {miss_addr[$bits(addr_t)-1:OFFSET_W], {OFFSET_W{1'b0}}};
	end

	assign busy     = (state != IDLE);
	assign mem_read = (state == FILL) && (issue_cnt < CNT_W'(BLOCK_WORDS)); // up to 8 in flight

	// word address on the issue count, byte bit stays zero
	assign fill_addr = base_addr
		| addr_t'({issue_cnt[WORD_SEL_W-1:0], 1'b0});

	assign fill_word        = rcv_cnt;
	assign write_data_array = (state == FILL) && mem_data_valid;
	assign write_tag_array  = (state == TAG);

endmodule

// ==== hw/meta_data_array.sv ====
module meta_data_array
	import cache_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  set_t  set,        // line being looked up or filled
	input  logic  write,      // mark line valid with tag_in
	input  tag_t  tag_in,
	output meta_t meta_out    // {valid, tag} of the addressed line
);

	logic [NUM_SETS-1:0] valid;              // one valid bit per line
	tag_t                tags [NUM_SETS];    // tag store, contents don't care until valid

	// valid bits, cleared together on reset
	always_ff @(posedge clk) begin
		if (rst)
			valid <= '0;
		else if (write)
			valid[set] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (write)
			tags[set] <= tag_in;
	end

	// combinational lookup, same cycle as the request
	assign meta_out = {valid[set], tags[set]};

endmodule

// ==== hw/data_array.sv ====
module data_array
	import cache_pkg::*, mem_pkg::*;
(
	input  logic      clk,
	input  set_t      set,       // line select
	input  word_sel_t word,      // word within the line
	input  logic      write,
	input  word_t     data_in,
	output word_t     data_out
);

	localparam int LINE_ADDR_W = SET_W + WORD_SEL_W;       // flat word index width
	localparam int DEPTH       = NUM_SETS * BLOCK_WORDS;   // 1024 words

	typedef logic [LINE_ADDR_W-1:0] array_addr_t;

	word_t       store [DEPTH];   // no reset, valid bits guard stale data
	array_addr_t waddr;

	// set and word select concatenate into one flat index
	assign waddr = {set, word};

	always_ff @(posedge clk) begin
		if (write)
			store[waddr] <= data_in;   // single write port
	end

	// read path is asynchronous so hits return in the request cycle
	assign data_out = store[waddr];

endmodule

// ==== hw/cache.sv ====
module cache
	import cache_pkg::*, mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst,

	// pipeline side
	input  logic  mem_read,
	input  addr_t read_addr,
	input  logic  mem_write,
	input  addr_t write_addr,
	input  word_t write_data,
	output word_t data_out,
	output logic  stall,
	output logic  hit,

	// memory side
	input  logic  mem_data_valid,
	input  word_t mem_read_data,
	output logic  cache_mem_read,
	output logic  cache_mem_write,
	output addr_t cache_mem_addr,
	output word_t cache_mem_write_data
);

	addr_t     req_addr;        // selected request address
	tag_t      req_tag;
	set_t      req_set;
	word_sel_t req_word;

	logic      busy;            // fill in progress
	logic      miss;
	addr_t     fill_addr;
	word_sel_t fill_word;
	logic      fill_data_we;
	logic      fill_tag_we;

	set_t      arr_set;         // array index, fill or pipeline
	word_sel_t arr_word;
	word_t     arr_data_in;
	logic      arr_data_we;
	meta_t     meta;
	logic      write_hit;

	// write wins when both are asserted
	assign req_addr = mem_write ? write_addr : read_addr;
	assign req_tag  = req_addr[TAG_LSB +: TAG_W];
	assign req_set  = req_addr[SET_LSB +: SET_W];
	assign req_word = req_addr[WORD_LSB +: WORD_SEL_W];

	assign hit       = meta[META_VALID] && (meta[TAG_W-1:0] == req_tag);
	assign miss      = (mem_read || mem_write) && !hit && !busy;
	assign write_hit = mem_write && hit && !busy;

	assign stall = busy || miss;   // rises in the miss cycle itself

	cache_fill_fsm u_fill (
		.clk              (clk),
		.rst              (rst),
		.miss             (miss),
		.miss_addr        (req_addr),
		.mem_data_valid   (mem_data_valid),
		.busy             (busy),
		.mem_read         (cache_mem_read),
		.fill_addr        (fill_addr),
		.fill_word        (fill_word),
		.write_data_array (fill_data_we),
		.write_tag_array  (fill_tag_we)
	);

	// fill owns the arrays while busy
	assign arr_set     = busy ? fill_addr[SET_LSB +: SET_W] : req_set;
	assign arr_word    = busy ? fill_word : req_word;
	assign arr_data_in = busy ? mem_read_data : write_data;
	assign arr_data_we = busy ? fill_data_we : write_hit;

	meta_data_array u_meta (
		.clk      (clk),
		.rst      (rst),
		.set      (arr_set),
		.write    (fill_tag_we),
		.tag_in   (fill_addr[TAG_LSB +: TAG_W]),   // same tag as the held request
		.meta_out (meta)
	);

	data_array u_data (
		.clk      (clk),
		.set      (arr_set),
		.word     (arr_word),
		.write    (arr_data_we),
		.data_in  (arr_data_in),
		.data_out (data_out)
	);

	// write-through, memory takes the word at the same edge as the cache
	assign cache_mem_write      = write_hit;
	assign cache_mem_addr       = busy ? fill_addr : req_addr;
	assign cache_mem_write_data = write_data;

endmodule

// ==== hw/main_memory.sv ====
module main_memory
	import mem_pkg::*;
#(
	parameter int MEM_LATENCY = 4   // read request to data_valid, at least 1
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  mem_read,
	input  logic  mem_write,
	input  addr_t addr,             // byte address, bit 0 ignored
	input  word_t write_data,
	output logic  data_valid,
	output word_t read_data
);

	typedef logic [$bits(addr_t)-2:0] word_addr_t;

	word_t      mem [MEM_WORDS];            // behavioral storage
	word_addr_t waddr;

	logic [MEM_LATENCY-1:0] valid_pipe;     // one stage per cycle of latency
	word_t                  data_pipe [MEM_LATENCY];

	assign waddr = addr[$bits(addr_t)-1:1];

	// power-up pattern 3*w+1, low 16 bits
	initial begin
		for (int w = 0; w < MEM_WORDS; w++)
			mem[w] = word_t'(w * 3 + 1);
	end

	// writes take effect at the edge
	always_ff @(posedge clk) begin
		if (mem_write)
			mem[waddr] <= write_data;
	end

	// valid stages, cleared by reset
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe[0] <= mem_read;
			for (int i = 1; i < MEM_LATENCY; i++)
				valid_pipe[i] <= valid_pipe[i-1];
		end
	end

	// data follows valid, sampled at request time
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[waddr];
		for (int i = 1; i < MEM_LATENCY; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	assign data_valid = valid_pipe[MEM_LATENCY-1];
	assign read_data  = data_pipe[MEM_LATENCY-1];   // in request order, never stalls

endmodule

// ==== hw/cache_mem_top.sv ====
module cache_mem_top
	import mem_pkg::*;
#(
	parameter int MEM_LATENCY = 4
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  mem_read,
	input  addr_t read_addr,
	input  logic  mem_write,
	input  addr_t write_addr,
	input  word_t write_data,
	output word_t data_out,
	output logic  stall,       // hold the request while high
	output logic  hit
);

	logic  cache_mem_read;
	logic  cache_mem_write;
	addr_t cache_mem_addr;
	word_t cache_mem_write_data;
	logic  mem_data_valid;
	word_t mem_read_data;

	cache u_cache (
		.clk                  (clk),
		.rst                  (rst),
		.mem_read             (mem_read),
		.read_addr            (read_addr),
		.mem_write            (mem_write),
		.write_addr           (write_addr),
		.write_data           (write_data),
		.data_out             (data_out),
		.stall                (stall),
		.hit                  (hit),
		.mem_data_valid       (mem_data_valid),
		.mem_read_data        (mem_read_data),
		.cache_mem_read       (cache_mem_read),
		.cache_mem_write      (cache_mem_write),
		.cache_mem_addr       (cache_mem_addr),
		.cache_mem_write_data (cache_mem_write_data)
	);

	main_memory #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clk        (clk),
		.rst        (rst),
		.mem_read   (cache_mem_read),
		.mem_write  (cache_mem_write),
		.addr       (cache_mem_addr),
		.write_data (cache_mem_write_data),
		.data_valid (mem_data_valid),
		.read_data  (mem_read_data)
	);

endmodule

// ==== test/cache_props.sv ====
module cache_props #(
	parameter int MEM_LATENCY = 4   // must match the memory behind the cache
) (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic busy,
	input logic cache_mem_read,
	input logic cache_mem_write,
	input logic mem_data_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;   // read back by the testbench at the end of the run

	// held request hits as soon as the fill is over
	stall_ends_with_fill: assert property (@(posedge clk) disable iff (rst)
		$fell(busy) |-> !stall)
		else begin
			fail_cnt++;
			$error("stall still high after the line fill ended");
		end

	// write-through never overlaps returning fill data
	no_write_in_fill: assert property (@(posedge clk) disable iff (rst)
		!(cache_mem_write && mem_data_valid))
		else begin
			fail_cnt++;
			$error("memory write issued during a line fill");
		end

	read_gives_valid: assert property (@(posedge clk) disable iff (rst)
		cache_mem_read |-> ##MEM_LATENCY mem_data_valid)
		else begin
			fail_cnt++;
			$error("memory read without data valid after the latency");
		end

	valid_needs_read: assert property (@(posedge clk) disable iff (rst)
		mem_data_valid |-> $past(cache_mem_read, MEM_LATENCY))
		else begin
			fail_cnt++;
			$error("data valid without a matching memory read");
		end

endmodule

bind cache cache_props #(
	.MEM_LATENCY (4)
) u_props (
	.clk             (clk),
	.rst             (rst),
	.stall           (stall),
	.busy            (busy),
	.cache_mem_read  (cache_mem_read),
	.cache_mem_write (cache_mem_write),
	.mem_data_valid  (mem_data_valid)
);

// ==== test/cache_tb.sv ====
module cache_tb
	import cache_pkg::*, mem_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD    = 20;
	localparam int MEM_LATENCY   = 4;
	localparam int STALL_TIMEOUT = 100;   // cycles allowed for one request
	localparam int RAND_OPS      = 200;
	localparam int SEED          = 75664;
	localparam int NUM_ROWS      = 21;

	typedef enum logic [1:0] {
		OP_RD,
		OP_WR,
		OP_RST
	} op_t;

	typedef struct packed {
		op_t   op;
		addr_t addr;
		word_t wdata;
		logic  exp_hit;    // hit in the request cycle
		word_t exp_data;   // read data once stall is low
	} stim_row_t;

	// set 0x12 holds tag 0 and tag 1 blocks, set 0x23 takes the write miss
	stim_row_t stim [NUM_ROWS] = '{
		'{OP_RD,  16'h0120, 16'h0000, 1'b0, 16'h01B1},   // cold read
		'{OP_RD,  16'h0122, 16'h0000, 1'b1, 16'h01B4},
		'{OP_RD,  16'h0124, 16'h0000, 1'b1, 16'h01B7},
		'{OP_RD,  16'h0126, 16'h0000, 1'b1, 16'h01BA},
		'{OP_RD,  16'h0128, 16'h0000, 1'b1, 16'h01BD},
		'{OP_RD,  16'h012A, 16'h0000, 1'b1, 16'h01C0},
		'{OP_RD,  16'h012C, 16'h0000, 1'b1, 16'h01C3},
		'{OP_RD,  16'h012E, 16'h0000, 1'b1, 16'h01C6},
		'{OP_RD,  16'h0920, 16'h0000, 1'b0, 16'h0DB1},   // conflict, tag 1
		'{OP_RD,  16'h0120, 16'h0000, 1'b0, 16'h01B1},   // original misses again
		'{OP_WR,  16'h0124, 16'hBEEF, 1'b1, 16'h0000},   // write hit
		'{OP_RD,  16'h0124, 16'h0000, 1'b1, 16'hBEEF},
		'{OP_RD,  16'h0924, 16'h0000, 1'b0, 16'h0DB7},   // evict written block
		'{OP_RD,  16'h0124, 16'h0000, 1'b0, 16'hBEEF},   // refill from memory
		'{OP_WR,  16'h1A34, 16'h5A5A, 1'b0, 16'h0000},   // write miss allocates
		'{OP_RD,  16'h1A34, 16'h0000, 1'b1, 16'h5A5A},
		'{OP_RD,  16'h1A30, 16'h0000, 1'b1, 16'h2749},
		'{OP_RD,  16'h1A36, 16'h0000, 1'b1, 16'h2752},
		'{OP_RST, 16'h0000, 16'h0000, 1'b0, 16'h0000},   // second reset
		'{OP_RD,  16'h1A34, 16'h0000, 1'b0, 16'h5A5A},
		'{OP_RD,  16'h0124, 16'h0000, 1'b0, 16'hBEEF}
	};

	logic  clk;
	logic  rst;
	logic  mem_read;
	logic  mem_write;
	addr_t read_addr;
	addr_t write_addr;
	word_t write_data;
	word_t data_out;
	logic  stall;
	logic  hit;

	word_t shadow_mem [MEM_WORDS];      // memory image, cache is write-through
	tag_t  shadow_tag [NUM_SETS];
	logic  shadow_valid [NUM_SETS];

	cache_mem_top #(
		.MEM_LATENCY (MEM_LATENCY)
	) UUT (
		.clk        (clk),
		.rst        (rst),
		.mem_read   (mem_read),
		.read_addr  (read_addr),
		.mem_write  (mem_write),
		.write_addr (write_addr),
		.write_data (write_data),
		.data_out   (data_out),
		.stall      (stall),
		.hit        (hit)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic shadow_hit(addr_t a);
		set_t s;
		s = a[SET_LSB +: SET_W];
		return shadow_valid[s] && (shadow_tag[s] == a[TAG_LSB +: TAG_W]);
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERR %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic update_shadow(input logic is_write, input addr_t a, input word_t wdata);
		shadow_valid[a[SET_LSB +: SET_W]] = 1'b1;   // line allocated on any miss
		shadow_tag[a[SET_LSB +: SET_W]]   = a[TAG_LSB +: TAG_W];
		if (is_write)
			shadow_mem[a >> 1] = wdata;
	endtask

	task automatic drive_idle();
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		read_addr  = '0;
		write_addr = '0;
		write_data = '0;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		drive_idle();
		rst = 1'b1;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		for (int s = 0; s < NUM_SETS; s++)
			shadow_valid[s] = 1'b0;   // all lines invalid after reset
	endtask

	// one request held until the first cycle with stall low
	task automatic do_request(input logic is_write, input addr_t a, input word_t wdata,
		output logic first_hit, output word_t rdata);
		int waited;
		waited = 0;
		@(negedge clk);
		mem_read   = !is_write;
		mem_write  = is_write;
		read_addr  = a;
		write_addr = a;
		write_data = wdata;
		#(CLK_PERIOD / 4);
		first_hit = hit;   // request cycle, before any fill
		while (stall) begin
			@(negedge clk);
			#(CLK_PERIOD / 4);
			waited++;
			if (waited > STALL_TIMEOUT) begin
				$display("stall did not end within %0d cycles for address %h",
					STALL_TIMEOUT, a);
				$display("ERRORS FOUND");
				$fatal(1, "stall timeout");
			end
		end
		check_eq(hit, 1'b1, "hit once stall is low");
		rdata = data_out;
		@(posedge clk);   // write lands at this edge
	endtask

	task automatic run_random();
		addr_t a;
		word_t wdata;
		logic  is_write;
		logic  exp_hit;
		word_t exp_data;
		logic  first_hit;
		word_t rdata;
		for (int i = 0; i < RAND_OPS; i++) begin
			a        = {tag_t'($urandom_range(2, 0)), set_t'(7'h10 + $urandom_range(3, 0)),
				word_sel_t'($urandom_range(7, 0)), 1'b0};   // 3 tags over 4 sets
			is_write = ($urandom_range(3, 0) == 0);
			wdata    = word_t'($urandom);
			exp_hit  = shadow_hit(a);
			exp_data = shadow_mem[a >> 1];
			do_request(is_write, a, wdata, first_hit, rdata);
			check_eq(first_hit, exp_hit, "random hit in request cycle");
			if (!is_write)
				check_eq(rdata, exp_data, "random read data");
			update_shadow(is_write, a, wdata);
		end
	endtask

	initial begin
		stim_row_t row;
		logic      first_hit;
		word_t     rdata;
		rst = 1'b1;
		drive_idle();
		void'($urandom(SEED));
		for (int w = 0; w < MEM_WORDS; w++)
			shadow_mem[w] = word_t'(w * 3 + 1);   // power-up memory contents
		apply_reset();
		for (int i = 0; i < NUM_ROWS; i++) begin
			row = stim[i];
			if (row.op == OP_RST) begin
				apply_reset();
			end else begin
				do_request(row.op == OP_WR, row.addr, row.wdata, first_hit, rdata);
				check_eq(first_hit, row.exp_hit, $sformatf("table row %0d hit", i));
				if (row.op == OP_RD)
					check_eq(rdata, row.exp_data, $sformatf("table row %0d data", i));
				update_shadow(row.op == OP_WR, row.addr, row.wdata);
			end
		end
		run_random();
		@(negedge clk);
		drive_idle();
		repeat (MEM_LATENCY + 2) @(posedge clk);   // let pending properties finish
		if (UUT.u_cache.u_props.fail_cnt != 0) begin
			$display("ERRORS FOUND");
			$fatal(1, "assertion failures");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

// ==== verilog.f ====
hw/mem_pkg.sv
hw/cache_pkg.sv
hw/cache_fill_fsm.sv
hw/meta_data_array.sv
hw/data_array.sv
hw/cache.sv
hw/main_memory.sv
hw/cache_mem_top.sv
test/cache_props.sv
test/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache_mem

sources:
  # packages first, modules in dependency order
  - hw/mem_pkg.sv
  - hw/cache_pkg.sv
  - hw/cache_fill_fsm.sv
  - hw/meta_data_array.sv
  - hw/data_array.sv
  - hw/cache.sv
  - hw/main_memory.sv
  - hw/cache_mem_top.sv

  - target: test
    files:
      - test/cache_props.sv
      - test/cache_tb.sv
